/* filelist.f */
src/fb_pkg.sv
src/display_timings.sv
src/line_drawer.sv
src/framebuffer_ram.sv
src/fb_scanout.sv
src/fb_line_top.sv
verif/tb_fb_line.sv

/* Makefile */
# Verilator build and run for the framebuffer row drawer testbench

VERILATOR ?= verilator
TOP       ?= tb_fb_line
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
PASS_MSG  ?= TEST OK

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_fb_line.sv */
/* tb_fb_line
   directed testbench for the row drawer and dvi scanout, checks every
   frame against a bit model of the 160x120 picture */
`default_nettype none
`timescale 1ns/10ps

module tb_fb_line;

    localparam int FRAME_CYCLES = fb_pkg::H_TOTAL * fb_pkg::V_TOTAL;  // 420000
    localparam int RESET_CYCLES = 5;
    // frames per test: sync 2, blank 1, draw 2, redraw 3, busy 2, and 2 spare
    localparam int TEST_FRAMES    = 12;
    localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_CYCLES;
    localparam int unsigned LCG_SEED = 42;

    logic          clk_pix;
    logic          rst_n;
    logic          draw_start;
    fb_pkg::fb_y_t line_y;
    logic          draw_colr;
    logic          busy;
    logic          done;
    logic          dvi_hsync;
    logic          dvi_vsync;
    logic          dvi_de;
    fb_pkg::colr_t dvi_r;
    fb_pkg::colr_t dvi_g;
    fb_pkg::colr_t dvi_b;

    bit          model [fb_pkg::FB_HEIGHT][fb_pkg::FB_WIDTH];  // starts blank like the RAM
    int unsigned lcg_state    = LCG_SEED;
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycles       = 0;
    int          done_count   = 0;  // every done pulse seen

    fb_line_top i_dut (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .draw_start (draw_start),
        .line_y     (line_y),
        .draw_colr  (draw_colr),
        .busy       (busy),
        .done       (done),
        .dvi_hsync  (dvi_hsync),
        .dvi_vsync  (dvi_vsync),
        .dvi_de     (dvi_de),
        .dvi_r      (dvi_r),
        .dvi_g      (dvi_g),
        .dvi_b      (dvi_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;  // 100 MHz sim clock
    end

    // hard limit on run length
    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d clock cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(negedge clk_pix) begin
        if (done) done_count++;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic fb_pkg::fb_y_t random_row();
        int unsigned r;
        r = lcg_next() >> 16;  // upper bits, low ones cycle fast
        return fb_pkg::fb_y_t'(r % fb_pkg::FB_HEIGHT);
    endfunction

    // white inside the framebuffer where the model bit is set
    function automatic fb_pkg::colr_t expected_colr(input int x, input int y);
        if (x < fb_pkg::FB_WIDTH && y < fb_pkg::FB_HEIGHT && model[y][x]) begin
            return '1;
        end
        return '0;
    endfunction

    task automatic check_colr(input string name, input fb_pkg::colr_t got,
                              input fb_pkg::colr_t expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s = %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("%-14s pass", name);
        end else begin
            tests_failed++;
            $display("%-14s fail, %0d errors", name, errors - errs_at_start);
        end
    endtask

    task automatic check_idle_outputs();
        check_bit("dvi_de", dvi_de, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("dvi_hsync", dvi_hsync, 1'b1);  // negative sync idles high
        check_bit("dvi_vsync", dvi_vsync, 1'b1);
        check_colr("dvi_r", dvi_r, '0);
        check_colr("dvi_g", dvi_g, '0);
        check_colr("dvi_b", dvi_b, '0);
    endtask

    // returns on the first falling edge where vsync has just come back high
    task automatic wait_vsync_rise();
        logic prev;
        prev = dvi_vsync;
        @(negedge clk_pix);
        while (prev || !dvi_vsync) begin
            prev = dvi_vsync;
            @(negedge clk_pix);
        end
    endtask

    // one whole frame from vsync end, position tracked from de and sync edges
    task automatic scan_frame(input bit check_geom, input bit check_pix);
        int            row;
        int            col;
        int            hs_run;
        int            hs_pulses;
        int            vs_run;
        int            vs_falls;
        logic          prev_de;
        logic          prev_hs;
        logic          prev_vs;
        fb_pkg::colr_t expected;
        string         where;
        wait_vsync_rise();
        row       = 0;
        col       = 0;
        hs_run    = 0;
        hs_pulses = 0;
        vs_run    = 0;
        vs_falls  = 0;
        prev_de   = 1'b0;
        prev_hs   = 1'b1;
        prev_vs   = 1'b1;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0) @(negedge clk_pix);
            if (dvi_de && check_pix) begin
                expected = expected_colr(col, row);
                if (dvi_r !== expected || dvi_g !== expected || dvi_b !== expected) begin
                    where = $sformatf(" at x %0d y %0d", col, row);
                    check_colr({"dvi_r", where}, dvi_r, expected);
                    check_colr({"dvi_g", where}, dvi_g, expected);
                    check_colr({"dvi_b", where}, dvi_b, expected);
                end
            end
            if (dvi_de) col++;
            if (prev_de && !dvi_de) begin  // end of an active line
                if (check_geom) check_count("de cycles per line", col, fb_pkg::H_ACTIVE);
                row++;
                col = 0;
            end
            if (!dvi_hsync) hs_run++;
            if (!prev_hs && dvi_hsync) begin
                if (check_geom) check_count("dvi_hsync low run", hs_run, fb_pkg::H_SYNC);
                hs_pulses++;
                hs_run = 0;
            end
            if (!dvi_vsync) vs_run++;
            if (prev_vs && !dvi_vsync) vs_falls++;
            prev_de = dvi_de;
            prev_hs = dvi_hsync;
            prev_vs = dvi_vsync;
        end
        if (check_geom) begin
            check_count("de lines per frame", row, fb_pkg::V_ACTIVE);
            check_count("hsync pulses per frame", hs_pulses, fb_pkg::V_TOTAL);
            check_count("dvi_vsync low cycles", vs_run, fb_pkg::V_SYNC * fb_pkg::H_TOTAL);
            check_count("vsync pulses per frame", vs_falls, 1);
        end
    endtask

    // one accepted request, model follows once done is seen
    task automatic draw_row(input fb_pkg::fb_y_t y, input logic colr);
        @(negedge clk_pix);
        draw_start = 1'b1;
        line_y     = y;
        draw_colr  = colr;
        @(negedge clk_pix);
        draw_start = 1'b0;
        check_bit("busy", busy, 1'b1);
        while (!done) @(negedge clk_pix);
        check_bit("busy", busy, 1'b0);  // drops with done
        for (int x = 0; x < fb_pkg::FB_WIDTH; x++) begin
            model[y][x] = colr;
        end
    endtask

    initial begin
        int            errs;
        int            done_before;
        fb_pkg::fb_y_t rand_y;
        rst_n      = 1'b0;
        draw_start = 1'b0;
        line_y     = '0;
        draw_colr  = 1'b0;

        errs = errors;
        repeat (RESET_CYCLES) begin
            @(negedge clk_pix);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        #1;
        check_idle_outputs();  // before the first active edge
        finish_test("reset_state", errs);

        errs = errors;
        scan_frame(1'b1, 1'b0);
        finish_test("sync_geometry", errs);

        errs = errors;
        scan_frame(1'b0, 1'b1);
        finish_test("blank_picture", errs);

        errs        = errors;
        done_before = done_count;
        draw_row(fb_pkg::fb_y_t'(60), 1'b1);
        scan_frame(1'b0, 1'b1);
        check_count("done pulses", done_count - done_before, 1);
        finish_test("draw_row", errs);

        errs   = errors;
        rand_y = random_row();
        draw_row(rand_y, 1'b1);
        draw_row(fb_pkg::fb_y_t'(60), 1'b0);  // erase the earlier row
        scan_frame(1'b0, 1'b1);
        finish_test($sformatf("erase_redraw (row %0d)", rand_y), errs);

        errs        = errors;
        done_before = done_count;
        @(negedge clk_pix);
        draw_start = 1'b1;
        line_y     = fb_pkg::fb_y_t'(20);
        draw_colr  = 1'b1;
        @(negedge clk_pix);
        draw_start = 1'b0;
        check_bit("busy", busy, 1'b1);
        @(negedge clk_pix);
        draw_start = 1'b1;                     // second request while busy
        line_y     = fb_pkg::fb_y_t'(100);
        @(negedge clk_pix);
        draw_start = 1'b0;
        while (!done) @(negedge clk_pix);
        for (int x = 0; x < fb_pkg::FB_WIDTH; x++) begin
            model[20][x] = 1'b1;
        end
        scan_frame(1'b1, 1'b1);                // spans another frame pulse
        check_count("done pulses", done_count - done_before, 1);
        finish_test("busy_request", errs);

        $display("tests %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/fb_line_top.sv */
/* fb_line_top
   display timing, row drawer, framebuffer RAM and scanout to dvi */
`default_nettype none
`timescale 1ns/10ps

module fb_line_top (
    input  wire logic          clk_pix,
    input  wire logic          rst_n,
    input  wire logic          draw_start,
    input  wire fb_pkg::fb_y_t line_y,
    input  wire logic          draw_colr,
    output      logic          busy,
    output      logic          done,
    output      logic          dvi_hsync,
    output      logic          dvi_vsync,
    output      logic          dvi_de,
    output      fb_pkg::colr_t dvi_r,
    output      fb_pkg::colr_t dvi_g,
    output      fb_pkg::colr_t dvi_b
);

    // screen position and timing
    fb_pkg::cord_t sx;
    fb_pkg::cord_t sy;
    logic          hsync;
    logic          vsync;
    logic          de;
    logic          frame;

    // framebuffer ports
    logic             fb_we;
    fb_pkg::fb_addr_t fb_addr_write;
    logic             fb_colr_write;
    fb_pkg::fb_addr_t fb_addr_read;
    logic             fb_colr_read;

    display_timings i_display_timings (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame)
    );

    line_drawer i_line_drawer (
        .clk_pix       (clk_pix),
        .rst_n         (rst_n),
        .frame         (frame),         // writes land in vertical blanking
        .draw_start    (draw_start),
        .line_y        (line_y),
        .draw_colr     (draw_colr),
        .busy          (busy),
        .done          (done),
        .fb_we         (fb_we),
        .fb_addr_write (fb_addr_write),
        .fb_colr_write (fb_colr_write)
    );

    framebuffer_ram i_framebuffer_ram (
        .clk_pix       (clk_pix),
        .fb_we         (fb_we),
        .fb_addr_write (fb_addr_write),
        .fb_colr_write (fb_colr_write),
        .fb_addr_read  (fb_addr_read),
        .fb_colr_read  (fb_colr_read)
    );

    fb_scanout i_fb_scanout (
        .clk_pix      (clk_pix),
        .rst_n        (rst_n),
        .sx           (sx),
        .sy           (sy),
        .hsync        (hsync),
        .vsync        (vsync),
        .de           (de),
        .frame        (frame),
        .fb_addr_read (fb_addr_read),
        .fb_colr_read (fb_colr_read),
        .dvi_hsync    (dvi_hsync),
        .dvi_vsync    (dvi_vsync),
        .dvi_de       (dvi_de),
        .dvi_r        (dvi_r),
        .dvi_g        (dvi_g),
        .dvi_b        (dvi_b)
    );

endmodule

`default_nettype wire

/* src/fb_scanout.sv */
/* fb_scanout
   walks the framebuffer in step with the screen position and turns
   each bit into 4-bit dvi colour, with sync delayed to match the RAM */
`default_nettype none
`timescale 1ns/10ps

module fb_scanout (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire fb_pkg::cord_t    sx,
    input  wire fb_pkg::cord_t    sy,
    input  wire logic             hsync,
    input  wire logic             vsync,
    input  wire logic             de,
    input  wire logic             frame,
    output      fb_pkg::fb_addr_t fb_addr_read,
    input  wire logic             fb_colr_read,
    output      logic             dvi_hsync,
    output      logic             dvi_vsync,
    output      logic             dvi_de,
    output      fb_pkg::colr_t    dvi_r,
    output      fb_pkg::colr_t    dvi_g,
    output      fb_pkg::colr_t    dvi_b
);

    logic paint;     // current position lies in the framebuffer
    logic paint_q;   // aligned with RAM data
    logic pix_on;

    always_comb begin
        paint = (sx < fb_pkg::cord_t'(fb_pkg::FB_WIDTH))
             && (sy < fb_pkg::cord_t'(fb_pkg::FB_HEIGHT));
    end

    // address starts at 0, so no extra latency at the top-left pixel
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            fb_addr_read <= '0;
        end else if (frame) begin
            fb_addr_read <= '0;  // rewind once per frame
        end else if (paint) begin
            fb_addr_read <= fb_addr_read + 1'b1;
        end
    end

    // one register stage for the RAM read
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            paint_q   <= 1'b0;
            dvi_hsync <= 1'b1;  // idle high
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
        end else begin
            paint_q   <= paint;
            dvi_hsync <= hsync;
            dvi_vsync <= vsync;
            dvi_de    <= de;
        end
    end

    // 1-bit pixel expands to full white on every channel
    always_comb begin
        pix_on = paint_q & fb_colr_read;  // outside the area reads are ignored
        dvi_r  = pix_on ? '1 : '0;
        dvi_g  = pix_on ? '1 : '0;
        dvi_b  = pix_on ? '1 : '0;
    end

endmodule

`default_nettype wire

/* src/framebuffer_ram.sv */
/* framebuffer_ram
   simple dual-port 1-bit framebuffer, one write port and one registered read port */
`default_nettype none
`timescale 1ns/10ps

module framebuffer_ram (
    input  wire logic             clk_pix,
    input  wire logic             fb_we,
    input  wire fb_pkg::fb_addr_t fb_addr_write,
    input  wire logic             fb_colr_write,
    input  wire fb_pkg::fb_addr_t fb_addr_read,
    output      logic             fb_colr_read    // valid one cycle after address
);

    logic mem [fb_pkg::FB_PIXELS];

    // picture starts blank
    initial begin
        for (int i = 0; i < fb_pkg::FB_PIXELS; i++) begin
            mem[i] = 1'b0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (fb_we) begin
            mem[fb_addr_write] <= fb_colr_write;
        end
    end

    // read before write on a shared address, new data a cycle later
    always_ff @(posedge clk_pix) begin
        fb_colr_read <= mem[fb_addr_read];
    end

endmodule

`default_nettype wire

/* src/line_drawer.sv */
/* line_drawer
   latches a row request, waits for the frame pulse and fills that
   framebuffer row with one colour, one pixel per clock */
`default_nettype none
`timescale 1ns/10ps

module line_drawer (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire logic             frame,          // start of vertical blanking
    input  wire logic             draw_start,     // one-cycle request
    input  wire fb_pkg::fb_y_t    line_y,         // row to fill
    input  wire logic             draw_colr,      // 1 paints and 0 erases
    output      logic             busy,
    output      logic             done,           // one cycle after last write
    output      logic             fb_we,
    output      fb_pkg::fb_addr_t fb_addr_write,
    output      logic             fb_colr_write
);

    typedef enum logic [1:0] {
        IDLE,
        ARMED,    // request held until frame
        DRAWING
    } state_t;

    state_t                    state;
    fb_pkg::fb_addr_t          row_base;  // first address of the requested row
    logic [fb_pkg::FB_XW-1:0]  col;       // column being written
    logic                      last_col;

    always_comb begin
        busy     = (state != IDLE);
        last_col = (int'(col) == fb_pkg::FB_WIDTH - 1);
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            fb_we <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;  // pulse
            case (state)
                IDLE: begin
                    if (draw_start) state <= ARMED;  // busy high next cycle
                end
                ARMED: begin
                    if (frame) begin
                        fb_we <= 1'b1;
                        state <= DRAWING;
                    end
                end
                DRAWING: begin
                    if (last_col) begin
                        fb_we <= 1'b0;  // 160 writes issued
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request payload and write address
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && draw_start) begin
            row_base      <= fb_pkg::fb_addr_t'(line_y * fb_pkg::FB_WIDTH);
            fb_colr_write <= draw_colr;
        end
        if (state == ARMED && frame) begin
            fb_addr_write <= row_base;
            col           <= '0;
        end else if (state == DRAWING) begin
            fb_addr_write <= fb_addr_write + 1'b1;  // one pixel per clock
            col           <= col + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/display_timings.sv */
/* display_timings
   640x480 screen position counters with negative sync, data enable
   and a frame pulse at the start of vertical blanking */
`default_nettype none
`timescale 1ns/10ps

module display_timings (
    input  wire logic          clk_pix,
    input  wire logic          rst_n,
    output      fb_pkg::cord_t sx,      // horizontal position
    output      fb_pkg::cord_t sy,      // vertical position
    output      logic          hsync,   // low during sync
    output      logic          vsync,
    output      logic          de,      // active picture
    output      logic          frame    // one cycle at sx 0, sy 480
);

    logic line_end;  // last pixel of the line
    logic last_line;

    // sync windows start after the front porch
    logic h_in_sync;
    logic v_in_sync;

    always_comb begin
        line_end  = (sx == fb_pkg::cord_t'(fb_pkg::H_TOTAL - 1));
        last_line = (sy == fb_pkg::cord_t'(fb_pkg::V_TOTAL - 1));
    end

    // free running counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            // sy only moves when sx wraps
            if (last_line) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        h_in_sync = (sx >= fb_pkg::cord_t'(fb_pkg::H_ACTIVE + fb_pkg::H_FP))
                 && (sx <  fb_pkg::cord_t'(fb_pkg::H_ACTIVE + fb_pkg::H_FP
                                           + fb_pkg::H_SYNC));      // 656..751
        v_in_sync = (sy >= fb_pkg::cord_t'(fb_pkg::V_ACTIVE + fb_pkg::V_FP))
                 && (sy <  fb_pkg::cord_t'(fb_pkg::V_ACTIVE + fb_pkg::V_FP
                                           + fb_pkg::V_SYNC));      // 490..491
    end

    always_comb begin
        hsync = ~h_in_sync;  // negative polarity
        vsync = ~v_in_sync;
        de    = (sx < fb_pkg::cord_t'(fb_pkg::H_ACTIVE))
             && (sy < fb_pkg::cord_t'(fb_pkg::V_ACTIVE));
        // first blanking line, leaves a full blanking interval for the drawer
        frame = (sy == fb_pkg::cord_t'(fb_pkg::V_ACTIVE)) && (sx == '0);
    end

endmodule

`default_nettype wire

/* src/fb_pkg.sv */
/* fb_pkg
   shared constants and types for the 640x480 display and the 1-bit framebuffer */
`default_nettype none

package fb_pkg;

    // horizontal timing, in pixels
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;   // front porch
    localparam int H_SYNC   = 96;   // sync width, negative polarity
    localparam int H_BP     = 48;   // back porch
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing, in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;    // negative polarity too
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 525

    // framebuffer sits in the top-left corner of the screen
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 19200 words of 1 bit
    localparam int FB_ADDRW  = 15;

    // widths
    localparam int CORDW = 10;  // enough for 0..799
    localparam int FB_XW = 8;   // column 0..159
    localparam int FB_YW = 7;   // row 0..119
    localparam int COLRW = 4;   // per dvi channel

    typedef logic [CORDW-1:0]    cord_t;
    typedef logic [FB_ADDRW-1:0] fb_addr_t;
    typedef logic [FB_YW-1:0]    fb_y_t;
    typedef logic [COLRW-1:0]    colr_t;

endpackage

`default_nettype wire
